// File: bridge_pwm.sv
/* h-bridge pwm with dead time */

`timescale 1ns/1ps

module bridge_pwm
(
  input  logic        clk,
  input  logic        reset_n,
  input  logic        en_i,
  input  logic [15:0] period_i,
  input  logic [7:0]  dead_i,
  output logic [3:0]  fets_o    // {b lo, b hi, a lo, a hi}
);

  ////////////////////
  // triangle counter

  logic [15:0] cnt;
  logic        dir_up;
  logic [15:0] period_q;   // taken at the valley
  logic [7:0]  dead_q;

  always_ff @(posedge clk)
  begin
    if (!reset_n || !en_i)
    begin
      cnt      <= '0;
      dir_up   <= 1'b1;
      period_q <= period_i;
      dead_q   <= dead_i;
    end
    else if (cnt == '0)
    begin
      period_q <= period_i;   // new settings only at the valley
      dead_q   <= dead_i;
      dir_up   <= 1'b1;
      cnt      <= cnt + 1'b1;
    end
    else if (dir_up && cnt >= period_q)
    begin
      dir_up <= 1'b0;         // peak, turn around
      cnt    <= cnt - 1'b1;
    end
    else if (dir_up)
      cnt <= cnt + 1'b1;
    else
      cnt <= cnt - 1'b1;
  end

  ////////////////////
  // legs

  logic       phase_a;        // leg a high side wanted
  logic [1:0] want_hi;
  logic [1:0] cur_hi;         // side each leg is heading to
  logic [7:0] dead_cnt [2];
  logic [3:0] fets_q;

  assign phase_a = cnt < (period_q >> 1);
  assign want_hi = {~phase_a, phase_a};  // leg b mirrors leg a

  always_ff @(posedge clk)
  begin
    if (!reset_n || !en_i)
    begin
      cur_hi      <= '0;
      dead_cnt[0] <= '0;
      dead_cnt[1] <= '0;
      fets_q      <= '0;      // all gates off
    end
    else
    begin
      for (int l = 0; l < 2; l++)
      begin
        if (want_hi[l] != cur_hi[l])
        begin
          cur_hi[l]        <= want_hi[l];
          dead_cnt[l]      <= dead_q;
          fets_q[2*l +: 2] <= 2'b00;    // blank the whole leg
        end
        else if (dead_cnt[l] != '0)
        begin
          dead_cnt[l]      <= dead_cnt[l] - 1'b1;
          fets_q[2*l +: 2] <= 2'b00;
        end
        else
          fets_q[2*l +: 2] <= {~cur_hi[l], cur_hi[l]};
      end
    end
  end

  assign fets_o = fets_q;

  a_no_shoot: assert property (@(posedge clk) disable iff (!reset_n)
    !(fets_o[0] && fets_o[1]) && !(fets_o[2] && fets_o[3]));

  // a leg only changes side by passing through all off
  a_break_make: assert property (@(posedge clk) disable iff (!reset_n)
    ($past(fets_o[1:0]) == 2'b00 || fets_o[1:0] == 2'b00 || $stable(fets_o[1:0])) &&
    ($past(fets_o[3:2]) == 2'b00 || fets_o[3:2] == 2'b00 || $stable(fets_o[3:2])));

endmodule

// File: buzzer_gen.sv
/* buzzer square wave */

`timescale 1ns/1ps

module buzzer_gen
(
  input  logic        clk,
  input  logic        reset_n,
  input  logic        en_i,
  input  logic [15:0] half_i,     // clocks per level
  output logic [1:0]  buzzer_o    // complementary drive
);

  logic [15:0] cnt;
  logic [1:0]  buzz_q;   // 00 idle, then 01 / 10

  always_ff @(posedge clk)
  begin
    if (!reset_n || !en_i)
    begin
      cnt    <= '0;
      buzz_q <= 2'b00;   // both sides low when quiet
    end
    else if (cnt == '0)
    begin
      // reload and flip, zero half treated as one
      cnt    <= (half_i == '0) ? '0 : half_i - 1'b1;
      buzz_q <= (buzz_q == 2'b01) ? 2'b10 : 2'b01;
    end
    else
      cnt <= cnt - 1'b1;
  end

  assign buzzer_o = buzz_q;

endmodule

// File: ctrl_regs.sv
/* control register bank */

`timescale 1ns/1ps

module ctrl_regs
  import pwr_reg_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset_n,
  input  reg_req_t             req_i,
  output logic [DATA_BITS-1:0] rdata_o,
  output ctrl_t                ctrl_o,
  input  logic [15:0]          rev_count_i
);

  ctrl_t                ctrl_q;
  status_t              status;
  logic [DATA_BITS-1:0] rd_word;
  logic [DATA_BITS-1:0] rdata_q;

  assign status = '{zero: 8'h00, magic: MAGIC, rev_count: rev_count_i};

  ////////////////////
  // write decode

  always_ff @(posedge clk)
  begin
    if (!reset_n)
      ctrl_q <= CTRL_RST;
    else if (req_i.wr_stb)
    begin
      case (req_i.addr)
        ADDR_CTRL:
        begin
          ctrl_q.bridge_en <= req_i.wdata[CTRL_BRIDGE_EN_BIT];
          ctrl_q.buzzer_en <= req_i.wdata[CTRL_BUZZER_EN_BIT];
          ctrl_q.fan_pulse <= req_i.wdata[CTRL_FAN_LSB +: FAN_PULSE_W];
        end
        ADDR_BRIDGE:
        begin
          ctrl_q.bridge_period <= req_i.wdata[15:0];
          ctrl_q.dead_time     <= req_i.wdata[BRIDGE_DEAD_LSB +: DEAD_W];
        end
        ADDR_BUZZ:
          ctrl_q.buzz_half <= req_i.wdata[15:0];
        ADDR_TACH:
          ctrl_q.tach_gate <= req_i.wdata;
        default:
          ;  // status and holes ignore writes
      endcase
    end
  end

  ////////////////////
  // read back

  always_comb
  begin
    rd_word = '0;  // unused bits and holes read 0
    case (req_i.addr)
      ADDR_CTRL:
      begin
        rd_word[CTRL_BRIDGE_EN_BIT]              = ctrl_q.bridge_en;
        rd_word[CTRL_BUZZER_EN_BIT]              = ctrl_q.buzzer_en;
        rd_word[CTRL_FAN_LSB +: FAN_PULSE_W]     = ctrl_q.fan_pulse;
      end
      ADDR_BRIDGE:
      begin
        rd_word[15:0]                            = ctrl_q.bridge_period;
        rd_word[BRIDGE_DEAD_LSB +: DEAD_W]       = ctrl_q.dead_time;
      end
      ADDR_BUZZ:   rd_word[15:0] = ctrl_q.buzz_half;
      ADDR_TACH:   rd_word       = ctrl_q.tach_gate;
      ADDR_STATUS: rd_word       = status;  // rev count sampled here
      default:     rd_word       = '0;
    endcase
  end

  // spi shifter loads this on the next cycle
  always_ff @(posedge clk)
  begin
    if (req_i.rd_stb)
      rdata_q <= rd_word;
  end

  assign rdata_o = rdata_q;
  assign ctrl_o  = ctrl_q;

endmodule

// File: fan_pwm.sv
/* fan pwm, active low */

`timescale 1ns/1ps

module fan_pwm
  import pwr_cfg_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic [9:0] pulse_i,   // low clocks per window
  output logic       pwm_o      // low turns the fet on
);

  logic [FAN_CNT_W-1:0] cnt;
  logic [9:0]           pulse_sat;
  logic                 pwm_q;

  // pulse longer than the window means always on
  assign pulse_sat = (pulse_i > 10'(FAN_PERIOD)) ? 10'(FAN_PERIOD) : pulse_i;

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      cnt   <= '0;
      pwm_q <= 1'b1;   // fan off
    end
    else
    begin
      cnt   <= (cnt == FAN_CNT_W'(FAN_PERIOD - 1)) ? '0 : cnt + 1'b1;
      pwm_q <= (10'(cnt) >= pulse_sat);   // low at window start
    end
  end

  assign pwm_o = pwm_q;

endmodule

// File: fan_tach.sv
/* fan tachometer */

`timescale 1ns/1ps

module fan_tach
  import pwr_cfg_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  input  logic        tach_i,
  input  logic [31:0] gate_i,       // window length in clocks
  output logic [15:0] rev_count_o
);

  logic [SYNC_STAGES-1:0] tach_sync;
  logic                   tach_d;
  logic                   tach_rise;
  logic [31:0]            gate_cnt;
  logic                   gate_end;    // last clock of the window
  logic [15:0]            rev_cnt;
  logic [15:0]            rev_q;

  assign tach_rise = tach_sync[SYNC_STAGES-1] & ~tach_d;
  assign gate_end  = (gate_i <= 32'd1) || (gate_cnt >= gate_i - 32'd1);

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      tach_sync <= '0;
      tach_d    <= 1'b0;
      gate_cnt  <= '0;
      rev_cnt   <= '0;
      rev_q     <= '0;
    end
    else
    begin
      tach_sync <= {tach_sync[SYNC_STAGES-2:0], tach_i};
      tach_d    <= tach_sync[SYNC_STAGES-1];
      if (gate_end)
      begin
        gate_cnt <= '0;
        rev_q    <= rev_cnt;               // publish last window
        rev_cnt  <= {15'd0, tach_rise};    // edge here belongs to next window
      end
      else
      begin
        gate_cnt <= gate_cnt + 1'b1;
        if (tach_rise && rev_cnt != '1)    // stick at max
          rev_cnt <= rev_cnt + 1'b1;
      end
    end
  end

  assign rev_count_o = rev_q;

endmodule

// File: filelist.f
pwr_cfg_pkg.sv
pwr_reg_pkg.sv
spi_slave.sv
ctrl_regs.sv
bridge_pwm.sv
buzzer_gen.sv
fan_pwm.sv
fan_tach.sv
pwr_ctrl_top.sv
tb_pwr_ctrl.sv

// File: pwr_cfg_pkg.sv
/* power stage timing constants */

package pwr_cfg_pkg;

  ////////////////////
  // clock

  localparam logic [31:0] CLK_FREQ = 32'd12_000_000;  // 12 mhz board oscillator

  ////////////////////
  // fan pwm

  // intel 4-wire fan spec, 21..28 khz allowed
  localparam int unsigned FAN_FREQ   = 25_000;
  localparam int unsigned FAN_PERIOD = CLK_FREQ / FAN_FREQ;  // 480 clocks
  localparam int unsigned FAN_CNT_W  = $clog2(FAN_PERIOD);   // window counter width

  ////////////////////
  // pins from off chip

  // sck, ss_n, mosi and tach are all async to clk
  localparam int unsigned SYNC_STAGES = 2;

endpackage

// File: pwr_ctrl_top.sv
/* power stage controller top */

`timescale 1ns/1ps

module pwr_ctrl_top
  import pwr_reg_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_n_i,
  input  logic       sck_i,
  input  logic       ss_n_i,
  input  logic       mosi_i,
  output logic       miso_o,
  output logic [3:0] fets_o,      // q1 hi, q2 lo on the left, q3 q4 right
  output logic [1:0] buzzer_o,
  output logic       fan_pwm_o,
  input  logic       fan_tach_i
);

  reg_req_t             req;
  logic [DATA_BITS-1:0] rdata;
  ctrl_t                ctrl;
  logic [15:0]          rev_count;

  ////////////////////
  // spi front end

  spi_slave spi_slave_inst (
    .clk     (clk_i),
    .reset_n (reset_n_i),
    .sck_i   (sck_i),
    .ss_n_i  (ss_n_i),
    .mosi_i  (mosi_i),
    .miso_o  (miso_o),
    .req_o   (req),
    .rdata_i (rdata)
  );

  ctrl_regs ctrl_regs_inst (
    .clk         (clk_i),
    .reset_n     (reset_n_i),
    .req_i       (req),
    .rdata_o     (rdata),
    .ctrl_o      (ctrl),
    .rev_count_i (rev_count)
  );

  ////////////////////
  // outputs

  bridge_pwm bridge_pwm_inst (
    .clk      (clk_i),
    .reset_n  (reset_n_i),
    .en_i     (ctrl.bridge_en),
    .period_i (ctrl.bridge_period),
    .dead_i   (ctrl.dead_time),
    .fets_o   (fets_o)
  );

  buzzer_gen buzzer_gen_inst (
    .clk      (clk_i),
    .reset_n  (reset_n_i),
    .en_i     (ctrl.buzzer_en),
    .half_i   (ctrl.buzz_half),
    .buzzer_o (buzzer_o)
  );

  fan_pwm fan_pwm_inst (
    .clk     (clk_i),
    .reset_n (reset_n_i),
    .pulse_i (ctrl.fan_pulse),
    .pwm_o   (fan_pwm_o)
  );

  fan_tach fan_tach_inst (
    .clk         (clk_i),
    .reset_n     (reset_n_i),
    .tach_i      (fan_tach_i),
    .gate_i      (ctrl.tach_gate),
    .rev_count_o (rev_count)
  );

endmodule

// File: pwr_reg_pkg.sv
/* register map and spi frame */

package pwr_reg_pkg;

  import pwr_cfg_pkg::*;

  localparam logic [7:0] MAGIC = 8'hAA;  // status id byte

  ////////////////////
  // spi frame, command byte then data word, msb first

  localparam int unsigned CMD_BITS    = 8;
  localparam int unsigned DATA_BITS   = 32;
  localparam int unsigned FRAME_BITS  = CMD_BITS + DATA_BITS;  // 40
  localparam int unsigned FRAME_CNT_W = $clog2(FRAME_BITS + 1);
  localparam int unsigned CMD_WR_BIT  = 7;  // write flag in command
  localparam int unsigned ADDR_W      = 3;  // cmd[2:0]

  ////////////////////
  // addresses

  localparam logic [ADDR_W-1:0] ADDR_CTRL   = 3'd0;
  localparam logic [ADDR_W-1:0] ADDR_BRIDGE = 3'd1;
  localparam logic [ADDR_W-1:0] ADDR_BUZZ   = 3'd2;
  localparam logic [ADDR_W-1:0] ADDR_TACH   = 3'd3;
  localparam logic [ADDR_W-1:0] ADDR_STATUS = 3'd4;  // read only

  // field positions in the data word
  localparam int unsigned CTRL_BRIDGE_EN_BIT = 0;
  localparam int unsigned CTRL_BUZZER_EN_BIT = 1;
  localparam int unsigned CTRL_FAN_LSB       = 16;
  localparam int unsigned BRIDGE_DEAD_LSB    = 16;
  localparam int unsigned FAN_PULSE_W        = 10;
  localparam int unsigned DEAD_W             = 8;

  typedef struct packed {
    logic                   bridge_en;
    logic                   buzzer_en;
    logic [FAN_PULSE_W-1:0] fan_pulse;      // low clocks per fan window
    logic [15:0]            bridge_period;  // half of switching cycle
    logic [DEAD_W-1:0]      dead_time;
    logic [15:0]            buzz_half;      // clocks per buzzer level
    logic [31:0]            tach_gate;      // tach window in clocks
  } ctrl_t;

  typedef struct packed {
    logic [7:0]  zero;
    logic [7:0]  magic;
    logic [15:0] rev_count;
  } status_t;

  typedef struct packed {
    logic                 wr_stb;
    logic                 rd_stb;
    logic [ADDR_W-1:0]    addr;
    logic [DATA_BITS-1:0] wdata;
  } reg_req_t;

  // out of reset, everything quiet, fan off
  localparam ctrl_t CTRL_RST = '{
    bridge_en:     1'b0,
    buzzer_en:     1'b0,
    fan_pulse:     '0,
    bridge_period: 16'd400,   // 15 khz bridge
    dead_time:     8'd4,
    buzz_half:     16'd1465,  // ~4 khz tone
    tach_gate:     CLK_FREQ   // 1 s window
  };

endpackage

// File: run_sim.sh
#!/bin/sh
# build and run the power controller testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_pwr_ctrl -f filelist.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "TB PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi

// File: spi_slave.sv
/* oversampled spi slave */

`timescale 1ns/1ps

module spi_slave
  import pwr_cfg_pkg::*, pwr_reg_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 sck_i,
  input  logic                 ss_n_i,
  input  logic                 mosi_i,
  output logic                 miso_o,
  output reg_req_t             req_o,
  input  logic [DATA_BITS-1:0] rdata_i
);

  ////////////////////
  // pin sync

  logic [SYNC_STAGES-1:0] sck_sync;
  logic [SYNC_STAGES-1:0] ss_sync;
  logic [SYNC_STAGES-1:0] mosi_sync;
  logic                   sck_d;      // last synced sck, for edges

  logic sck_s;
  logic ss_s;
  logic mosi_s;
  logic sck_rise;
  logic sck_fall;

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      sck_sync  <= '0;
      ss_sync   <= '1;    // deselected
      mosi_sync <= '0;
      sck_d     <= 1'b0;
    end
    else
    begin
      sck_sync  <= {sck_sync[SYNC_STAGES-2:0], sck_i};
      ss_sync   <= {ss_sync[SYNC_STAGES-2:0], ss_n_i};
      mosi_sync <= {mosi_sync[SYNC_STAGES-2:0], mosi_i};
      sck_d     <= sck_s;
    end
  end

  assign sck_s    = sck_sync[SYNC_STAGES-1];
  assign ss_s     = ss_sync[SYNC_STAGES-1];
  assign mosi_s   = mosi_sync[SYNC_STAGES-1];
  assign sck_rise = sck_s & ~sck_d;
  assign sck_fall = ~sck_s & sck_d;

  ////////////////////
  // frame

  logic [FRAME_CNT_W-1:0] bit_cnt;    // rising edges seen this frame
  logic [DATA_BITS-1:0]   shift_in;
  logic [DATA_BITS-1:0]   tx_sr;      // read word going out
  logic                   wr_flag_q;
  logic                   load_q;     // rdata valid this cycle
  logic                   miso_q;
  logic                   take_bit;
  logic                   give_bit;
  reg_req_t               req_q;

  // mode 0, sample on rise, change on fall
  assign take_bit = sck_rise && !ss_s && (bit_cnt < FRAME_BITS);
  assign give_bit = sck_fall && !ss_s && (bit_cnt >= CMD_BITS) && (bit_cnt < FRAME_BITS);

  always_ff @(posedge clk)
  begin
    // data path
    if (take_bit)
      shift_in <= {shift_in[DATA_BITS-2:0], mosi_s};
    if (take_bit && bit_cnt == CMD_BITS - 1)
      req_q.addr <= {shift_in[ADDR_W-2:0], mosi_s};
    if (take_bit && bit_cnt == FRAME_BITS - 1)
      req_q.wdata <= {shift_in[DATA_BITS-2:0], mosi_s};
    if (load_q)
      tx_sr <= rdata_i;
    else if (give_bit)
      tx_sr <= {tx_sr[DATA_BITS-2:0], 1'b0};

    // control
    if (!reset_n)
    begin
      bit_cnt      <= '0;
      wr_flag_q    <= 1'b0;
      load_q       <= 1'b0;
      miso_q       <= 1'b0;
      req_q.rd_stb <= 1'b0;
      req_q.wr_stb <= 1'b0;
    end
    else
    begin
      req_q.rd_stb <= 1'b0;           // single cycle strobes
      req_q.wr_stb <= 1'b0;
      load_q       <= req_q.rd_stb;   // regs answer one cycle after rd_stb
      if (ss_s)
      begin
        bit_cnt <= '0;                // also drops a partial frame
        miso_q  <= 1'b0;
      end
      else
      begin
        if (take_bit)
        begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == CMD_BITS - 1)
          begin
            wr_flag_q    <= shift_in[CMD_WR_BIT-1];  // bit 7 of the command
            req_q.rd_stb <= 1'b1;
          end
          if (bit_cnt == FRAME_BITS - 1)
            req_q.wr_stb <= wr_flag_q;  // 40th bit, commit
        end
        if (give_bit)
          miso_q <= tx_sr[DATA_BITS-1];
      end
    end
  end

  assign req_o  = req_q;
  assign miso_o = miso_q;

  // read fires at bit 8, write at bit 40, never in one cycle
  a_one_strobe: assert property (@(posedge clk) disable iff (!reset_n)
    !(req_o.wr_stb && req_o.rd_stb));

endmodule

// File: tb_pwr_ctrl.sv
/* power controller testbench */

`timescale 1ns/1ps

module tb_pwr_ctrl
  import pwr_cfg_pkg::*, pwr_reg_pkg::*;
();

  localparam int HALF = 6;  // sck half period, clk cycles

  logic       clk = 1'b0;
  logic       reset_n = 1'b0;
  logic       sck = 1'b0;
  logic       ss_n = 1'b1;
  logic       mosi = 1'b0;
  logic       fan_tach = 1'b0;
  logic       miso;
  logic [3:0] fets;
  logic [1:0] buzzer;
  logic       fan_pwm;

  integer      seed = 32'h8cd8;
  int          err_cnt = 0;    // wrong values
  int          tmo_cnt = 0;    // waits that ran out
  logic [31:0] model [8];      // expected register contents
  longint      cyc = 0;

  pwr_ctrl_top pwr_ctrl_top_inst (
    .clk_i      (clk),
    .reset_n_i  (reset_n),
    .sck_i      (sck),
    .ss_n_i     (ss_n),
    .mosi_i     (mosi),
    .miso_o     (miso),
    .fets_o     (fets),
    .buzzer_o   (buzzer),
    .fan_pwm_o  (fan_pwm),
    .fan_tach_i (fan_tach)
  );

  always #50 clk = ~clk;  // 10 mhz bench clock

  always @(negedge clk)
    cyc <= cyc + 1;

  ////////////////////
  // helpers

  function automatic int unsigned rand_below(input int unsigned n);
    rand_below = $unsigned($random(seed)) % n;
  endfunction

  // defined bits per address, holes and status keep nothing
  function automatic logic [31:0] field_mask(input logic [2:0] a);
    case (a)
      3'd0:    field_mask = 32'h03FF_0003;  // fan_pulse, buzzer_en, bridge_en
      3'd1:    field_mask = 32'h00FF_FFFF;  // dead_time, bridge_period
      3'd2:    field_mask = 32'h0000_FFFF;
      3'd3:    field_mask = 32'hFFFF_FFFF;
      default: field_mask = 32'h0000_0000;
    endcase
  endfunction

  task automatic finish_run();
    $display("summary: %0d value errors, %0d timeouts", err_cnt, tmo_cnt);
    if (err_cnt == 0 && tmo_cnt == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    tmo_cnt++;
  endtask

  ////////////////////
  // spi host, mode 0

  task automatic spi_xfer(input logic [7:0] cmd, input logic [31:0] wdata,
                          input int nbits, output logic [31:0] rdata);
    logic [39:0] frame;
    frame = {cmd, wdata};
    rdata = '0;
    @(posedge clk);
    ss_n <= 1'b0;
    sck  <= 1'b0;
    mosi <= frame[39];
    for (int i = 0; i < nbits; i++)
    begin
      repeat (HALF - 1) @(posedge clk);
      @(negedge clk);  // miso settled since last fall
      if (i >= 8)
        rdata = {rdata[30:0], miso};
      else
        assert (miso == 1'b0)
        else
        begin
          $display("error: miso = %h during command bit %0d, expected 0", miso, i);
          err_cnt++;
        end
      @(posedge clk);
      sck <= 1'b1;
      repeat (HALF) @(posedge clk);
      sck <= 1'b0;
      if (i < 39)
        mosi <= frame[38 - i];
    end
    repeat (HALF) @(posedge clk);
    ss_n <= 1'b1;
    mosi <= 1'b0;
    repeat (2 * HALF) @(posedge clk);  // idle gap
  endtask

  task automatic reg_write(input logic [2:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    spi_xfer({1'b1, 4'b0000, addr}, data, 40, unused);
    model[addr] = data & field_mask(addr);
  endtask

  task automatic reg_read(input logic [2:0] addr, output logic [31:0] rd);
    spi_xfer({1'b0, 4'b0000, addr}, 32'h0, 40, rd);
  endtask

  task automatic check_reg(input logic [2:0] addr);
    logic [31:0] rd;
    reg_read(addr, rd);
    assert (rd == model[addr])
    else
    begin
      $display("error: rdata at addr %0d = %h, expected %h", addr, rd, model[addr]);
      err_cnt++;
    end
  endtask

  ////////////////////
  // output monitors, sampled mid cycle

  logic       bridge_mon = 1'b0;
  int         period_exp;
  int         dead_exp;
  int         rises;
  longint     last_rise;
  int         off_run [2];
  logic [1:0] leg_seen;
  logic [3:0] fets_d = '0;

  always @(negedge clk)
  begin
    assert (!(fets[0] && fets[1]) && !(fets[2] && fets[3]))
    else
    begin
      $display("error: fets_o = %h, high and low side on together", fets);
      err_cnt++;
    end
    if (bridge_mon)
    begin
      if (fets[0] && !fets_d[0])
      begin
        if (rises >= 2)  // first interval follows the enable
          assert (cyc - last_rise == 2 * period_exp)
          else
          begin
            $display("error: fets_o[0] rise spacing = %h, expected %h",
                     cyc - last_rise, 2 * period_exp);
            err_cnt++;
          end
        last_rise = cyc;
        rises++;
      end
      for (int l = 0; l < 2; l++)
      begin
        if (fets[2*l +: 2] == 2'b00)
          off_run[l]++;
        else
        begin
          if (fets_d[2*l +: 2] == 2'b00 && leg_seen[l])
            assert (off_run[l] >= dead_exp)
            else
            begin
              $display("error: leg %0d off time = %h, dead_time %h", l, off_run[l], dead_exp);
              err_cnt++;
            end
          leg_seen[l] = 1'b1;
          off_run[l]  = 0;
        end
      end
    end
    fets_d = fets;
  end

  logic       buzz_mon = 1'b0;
  int         buzz_exp;
  int         buzz_run;
  int         buzz_flips;
  logic       buzz_started;
  logic [1:0] buzzer_d = '0;

  always @(negedge clk)
  begin
    if (buzz_mon)
    begin
      assert (buzzer == 2'b01 || buzzer == 2'b10)
      else
      begin
        $display("error: buzzer_o = %h, not complementary", buzzer);
        err_cnt++;
      end
      if (buzzer != buzzer_d)
      begin
        if (buzz_started)
          assert (buzz_run == buzz_exp)
          else
          begin
            $display("error: buzzer_o level length = %h, expected %h", buzz_run, buzz_exp);
            err_cnt++;
          end
        buzz_started = 1'b1;
        buzz_run     = 1;
        buzz_flips++;
      end
      else
        buzz_run++;
    end
    buzzer_d = buzzer;
  end

  logic   fan_mon = 1'b0;
  int     pulse_exp;
  int     falls;
  int     low_run;
  longint last_fall;
  logic   fan_pwm_d = 1'b1;

  always @(negedge clk)
  begin
    if (fan_mon)
    begin
      if (!fan_pwm && fan_pwm_d)
      begin
        if (falls > 0)
          assert (cyc - last_fall == FAN_PERIOD)
          else
          begin
            $display("error: fan_pwm_o fall spacing = %h, expected %h",
                     cyc - last_fall, FAN_PERIOD);
            err_cnt++;
          end
        last_fall = cyc;
        falls++;
        low_run = 1;
      end
      else if (!fan_pwm)
        low_run++;
      else if (!fan_pwm_d && falls > 0)
        assert (low_run == pulse_exp)
        else
        begin
          $display("error: fan_pwm_o low time = %h, expected %h", low_run, pulse_exp);
          err_cnt++;
        end
    end
    fan_pwm_d = fan_pwm;
  end

  // tach pulse train, period 2 * tach_half
  logic tach_on = 1'b0;
  int   tach_half = 10;
  int   tach_cnt = 0;

  always @(posedge clk)
  begin
    if (tach_on)
    begin
      if (tach_cnt >= tach_half - 1)
      begin
        tach_cnt <= 0;
        fan_tach <= ~fan_tach;
      end
      else
        tach_cnt <= tach_cnt + 1;
    end
  end

  ////////////////////
  // test sequence

  initial
  begin : run_tests
    logic [31:0] rd;
    int          guard;
    int          gate;
    int          rev_exp;
    model[0] = 32'h0;
    model[1] = {8'h00, 8'd4, 16'd400};  // dead 4, period 400
    model[2] = 32'd1465;
    model[3] = CLK_FREQ;
    for (int a = 4; a < 8; a++)
      model[a] = 32'h0;
    repeat (8) @(posedge clk);
    reset_n <= 1'b1;
    @(negedge clk);
    assert (fets == 4'h0 && buzzer == 2'h0 && fan_pwm == 1'b1 && miso == 1'b0)
    else
    begin
      $display("error: after reset fets_o = %h buzzer_o = %h fan_pwm_o = %h miso_o = %h",
               fets, buzzer, fan_pwm, miso);
      err_cnt++;
    end

    // reset values, then random round trip
    for (int a = 0; a < 8; a++)
      if (a != ADDR_STATUS)
        check_reg(3'(a));
    for (int a = 0; a < 8; a++)
      if (a != ADDR_STATUS)
        reg_write(3'(a), $random(seed));
    for (int a = 0; a < 8; a++)
      if (a != ADDR_STATUS)
        check_reg(3'(a));
    reg_read(ADDR_STATUS, rd);
    assert (rd[31:16] == {8'h00, MAGIC})
    else
    begin
      $display("error: status[31:16] = %h, expected %h", rd[31:16], {8'h00, MAGIC});
      err_cnt++;
    end

    // frame cut after 20 bits writes nothing
    spi_xfer({1'b1, 4'b0000, ADDR_BUZZ}, $random(seed), 20, rd);
    check_reg(ADDR_BUZZ);

    ////////////////////
    // bridge

    reg_write(ADDR_CTRL, 32'h0);
    period_exp = 16 + rand_below(64);
    dead_exp   = 1 + rand_below(8);
    reg_write(ADDR_BRIDGE, {8'h00, 8'(dead_exp), 16'(period_exp)});
    rises      = 0;
    off_run[0] = 0;
    off_run[1] = 0;
    leg_seen   = 2'b00;
    bridge_mon = 1'b1;
    reg_write(ADDR_CTRL, 32'h1);
    guard = 0;
    while (rises < 6 && guard < 20000)
    begin
      @(posedge clk);
      guard++;
    end
    if (rises < 6)
      report_timeout("bridge switching cycles");
    bridge_mon = 1'b0;
    reg_write(ADDR_CTRL, 32'h0);

    ////////////////////
    // buzzer

    buzz_exp = 4 + rand_below(64);
    reg_write(ADDR_BUZZ, 32'(buzz_exp));
    reg_write(ADDR_CTRL, 32'h2);
    guard = 0;
    while (buzzer == 2'b00 && guard < 1000)
    begin
      @(negedge clk);
      guard++;
    end
    if (buzzer == 2'b00)
      report_timeout("buzzer start");
    buzz_started = 1'b0;
    buzz_flips   = 0;
    buzz_mon     = 1'b1;
    guard = 0;
    while (buzz_flips < 6 && guard < 5000)
    begin
      @(posedge clk);
      guard++;
    end
    if (buzz_flips < 6)
      report_timeout("buzzer level changes");
    buzz_mon = 1'b0;
    reg_write(ADDR_CTRL, 32'h0);
    @(negedge clk);
    assert (buzzer == 2'b00)
    else
    begin
      $display("error: buzzer_o = %h after disable, expected 0", buzzer);
      err_cnt++;
    end

    ////////////////////
    // fan pwm, then a pulse past the window

    pulse_exp = 1 + rand_below(FAN_PERIOD - 1);
    reg_write(ADDR_CTRL, 32'(pulse_exp) << 16);
    falls   = 0;
    fan_mon = 1'b1;
    guard = 0;
    while (falls < 5 && guard < 5000)
    begin
      @(posedge clk);
      guard++;
    end
    if (falls < 5)
      report_timeout("fan pwm windows");
    fan_mon = 1'b0;
    reg_write(ADDR_CTRL, (32'(FAN_PERIOD) + 32'(rand_below(544))) << 16);
    repeat (FAN_PERIOD + 10)
    begin
      @(negedge clk);
      assert (fan_pwm == 1'b0)
      else
      begin
        $display("error: fan_pwm_o = %h with saturated pulse, expected 0", fan_pwm);
        err_cnt++;
      end
    end
    reg_write(ADDR_CTRL, 32'h0);

    ////////////////////
    // tach over two gate windows

    tach_half = 10 + rand_below(10);
    @(negedge clk);
    tach_on = 1'b1;
    gate = 2000 + rand_below(1000);
    reg_write(ADDR_TACH, 32'(gate));
    repeat (2 * gate) @(posedge clk);
    reg_read(ADDR_STATUS, rd);
    rev_exp = gate / (2 * tach_half);
    assert (int'(rd[15:0]) >= rev_exp - 1 && int'(rd[15:0]) <= rev_exp + 1)
    else
    begin
      $display("error: rev_count = %h, expected %h within one", rd[15:0], rev_exp);
      err_cnt++;
    end
    tach_on = 1'b0;

    finish_run();
  end

endmodule
